//--- design/aes_package.sv
`default_nettype none

package aes_package;

  // Word and bus widths
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned REG_ADDR_W = 4;

  // One cipher block is four memory words
  localparam int unsigned BLOCK_W         = 128;
  localparam int unsigned WORDS_PER_BLOCK = 4;
  localparam int unsigned WORD_IDX_W      = $clog2(WORDS_PER_BLOCK);

  // Byte-address step between consecutive words
  localparam int unsigned WORD_BYTES = 4;

  // Bit positions in the status word
  localparam int unsigned STATUS_BUSY_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

  // Job control states
  typedef enum logic [2:0] {
    AES_IDLE     = 3'd0,
    AES_LOAD     = 3'd1,
    AES_MIX      = 3'd2,
    AES_STORE    = 3'd3,
    AES_FINISHED = 3'd4
  } aes_state_t;

  // Host register map
  typedef enum logic [REG_ADDR_W-1:0] {
    AES_REG_TRIGGER  = 4'd0,
    AES_REG_STATUS   = 4'd1,
    AES_REG_SRC_BASE = 4'd2,
    AES_REG_DST_BASE = 4'd3,
    AES_REG_KEY0     = 4'd4,
    AES_REG_KEY1     = 4'd5,
    AES_REG_KEY2     = 4'd6,
    AES_REG_KEY3     = 4'd7
  } aes_reg_t;

endpackage

`default_nettype wire

//--- design/aes_regfile.sv
`default_nettype none

module aes_regfile (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  cfg_we_i,
  input  logic [aes_package::REG_ADDR_W-1:0]    cfg_addr_i,
  input  logic [aes_package::DATA_W-1:0]        cfg_wdata_i,
  output logic [aes_package::DATA_W-1:0]        cfg_rdata_o,
  input  logic                                  busy_i,
  input  logic                                  done_i,
  output logic                                  start_o,
  output logic [aes_package::DATA_W-1:0]        src_base_o,
  output logic [aes_package::DATA_W-1:0]        dst_base_o,
  output logic [aes_package::BLOCK_W-1:0]       key_o
);

  logic [aes_package::DATA_W-1:0] src_base_q;
  logic [aes_package::DATA_W-1:0] dst_base_q;
  logic [aes_package::WORDS_PER_BLOCK-1:0][aes_package::DATA_W-1:0] key_q;
  logic start_q;
  logic done_q;
  logic trig_accept;

  // A new trigger counts only while no job is pending or running
  assign trig_accept = cfg_we_i && (cfg_addr_i == aes_package::AES_REG_TRIGGER)
                       && !busy_i && !start_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= trig_accept;
      if (trig_accept)
        done_q <= 1'b0;
      else if (done_i)
        done_q <= 1'b1;
    end
  end

  // Configuration words
  always_ff @(posedge clk) begin
    if (cfg_we_i) begin
      case (aes_package::aes_reg_t'(cfg_addr_i))
        aes_package::AES_REG_SRC_BASE: src_base_q <= cfg_wdata_i;
        aes_package::AES_REG_DST_BASE: dst_base_q <= cfg_wdata_i;
        aes_package::AES_REG_KEY0:     key_q[0]   <= cfg_wdata_i;
        aes_package::AES_REG_KEY1:     key_q[1]   <= cfg_wdata_i;
        aes_package::AES_REG_KEY2:     key_q[2]   <= cfg_wdata_i;
        aes_package::AES_REG_KEY3:     key_q[3]   <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // Read mux, busy also covers the start cycle
  always_comb begin
    cfg_rdata_o = '0;
    case (aes_package::aes_reg_t'(cfg_addr_i))
      aes_package::AES_REG_STATUS: begin
        cfg_rdata_o[aes_package::STATUS_BUSY_BIT] = busy_i | start_q;
        cfg_rdata_o[aes_package::STATUS_DONE_BIT] = done_q;
      end
      aes_package::AES_REG_SRC_BASE: cfg_rdata_o = src_base_q;
      aes_package::AES_REG_DST_BASE: cfg_rdata_o = dst_base_q;
      aes_package::AES_REG_KEY0:     cfg_rdata_o = key_q[0];
      aes_package::AES_REG_KEY1:     cfg_rdata_o = key_q[1];
      aes_package::AES_REG_KEY2:     cfg_rdata_o = key_q[2];
      aes_package::AES_REG_KEY3:     cfg_rdata_o = key_q[3];
      default: ;
    endcase
  end

  assign start_o    = start_q;
  assign src_base_o = src_base_q;
  assign dst_base_o = dst_base_q;
  assign key_o      = key_q;

endmodule

`default_nettype wire

//--- design/aes_fsm.sv
`default_nettype none

module aes_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic start_i,
  input  logic load_done_i,
  input  logic store_done_i,
  output logic load_start_o,
  output logic mix_en_o,
  output logic store_start_o,
  output logic busy_o,
  output logic done_o
);

  aes_package::aes_state_t current_state;
  aes_package::aes_state_t next_state;

  // State register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      current_state <= aes_package::AES_IDLE;
    else
      current_state <= next_state;
  end

  // Next-state logic
  always_comb begin
    next_state = current_state;
    case (current_state)
      aes_package::AES_IDLE: begin
        if (start_i)
          next_state = aes_package::AES_LOAD;
      end
      aes_package::AES_LOAD: begin
        if (load_done_i)
          next_state = aes_package::AES_MIX;
      end
      // Single cycle for the round-key step
      aes_package::AES_MIX: begin
        next_state = aes_package::AES_STORE;
      end
      aes_package::AES_STORE: begin
        if (store_done_i)
          next_state = aes_package::AES_FINISHED;
      end
      aes_package::AES_FINISHED: begin
        next_state = aes_package::AES_IDLE;
      end
      default: begin
        next_state = aes_package::AES_IDLE;
      end
    endcase
  end

  // Outputs, strobes fire on the transition into the next phase
  always_comb begin
    load_start_o  = 1'b0;
    mix_en_o      = 1'b0;
    store_start_o = 1'b0;
    busy_o        = 1'b1;
    done_o        = 1'b0;
    case (current_state)
      aes_package::AES_IDLE: begin
        busy_o       = 1'b0;
        load_start_o = start_i;
      end
      aes_package::AES_MIX: begin
        mix_en_o      = 1'b1;
        store_start_o = 1'b1;
      end
      aes_package::AES_FINISHED: begin
        done_o = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/aes_source.sv
`default_nettype none

module aes_source (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               load_start_i,
  input  logic [aes_package::DATA_W-1:0]     src_base_i,
  output logic                               rd_req_o,
  output logic [aes_package::DATA_W-1:0]     rd_addr_o,
  input  logic [aes_package::DATA_W-1:0]     rd_data_i,
  output logic                               load_done_o,
  output logic [aes_package::BLOCK_W-1:0]    block_o
);

  localparam logic [aes_package::WORD_IDX_W-1:0] LAST_WORD =
    aes_package::WORD_IDX_W'(aes_package::WORDS_PER_BLOCK - 1);

  logic                                  active_q;
  logic [aes_package::WORD_IDX_W-1:0]    cnt_q;
  logic                                  cap_q;
  logic [aes_package::WORD_IDX_W-1:0]    cap_idx_q;
  logic                                  load_done_q;
  logic [aes_package::WORDS_PER_BLOCK-1:0][aes_package::DATA_W-1:0] block_q;

  // Request counter plus capture pointer one cycle behind it
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q    <= 1'b0;
      cnt_q       <= '0;
      cap_q       <= 1'b0;
      cap_idx_q   <= '0;
      load_done_q <= 1'b0;
    end else begin
      if (load_start_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (active_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == LAST_WORD)
          active_q <= 1'b0;
      end
      cap_q       <= active_q;
      cap_idx_q   <= cnt_q;
      load_done_q <= cap_q && (cap_idx_q == LAST_WORD);
    end
  end

  // Read data lands in its block slot
  always_ff @(posedge clk) begin
    if (cap_q)
      block_q[cap_idx_q] <= rd_data_i;
  end

  assign rd_req_o    = active_q;
  assign rd_addr_o   = src_base_i
                       + {{(aes_package::DATA_W - aes_package::WORD_IDX_W){1'b0}}, cnt_q}
                       * aes_package::WORD_BYTES;
  assign load_done_o = load_done_q;
  assign block_o     = block_q;

endmodule

`default_nettype wire

//--- design/aes_sink.sv
`default_nettype none

module aes_sink (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               store_start_i,
  input  logic [aes_package::DATA_W-1:0]     dst_base_i,
  input  logic [aes_package::BLOCK_W-1:0]    result_i,
  output logic                               wr_en_o,
  output logic [aes_package::DATA_W-1:0]     wr_addr_o,
  output logic [aes_package::DATA_W-1:0]     wr_data_o,
  output logic                               store_done_o
);

  localparam logic [aes_package::WORD_IDX_W-1:0] LAST_WORD =
    aes_package::WORD_IDX_W'(aes_package::WORDS_PER_BLOCK - 1);

  logic                               active_q;
  logic [aes_package::WORD_IDX_W-1:0] cnt_q;

  // Walk the four result words, one write per cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (store_start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == LAST_WORD)
        active_q <= 1'b0;
    end
  end

  assign wr_en_o      = active_q;
  assign wr_addr_o    = dst_base_i
                        + {{(aes_package::DATA_W - aes_package::WORD_IDX_W){1'b0}}, cnt_q}
                        * aes_package::WORD_BYTES;
  assign wr_data_o    = result_i[cnt_q*aes_package::DATA_W +: aes_package::DATA_W];
  // Done goes out with the last write
  assign store_done_o = active_q && (cnt_q == LAST_WORD);

endmodule

`default_nettype wire

//--- design/aes_add_round_key.sv
`default_nettype none

module aes_add_round_key (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               mix_en_i,
  input  logic [aes_package::BLOCK_W-1:0]    block_i,
  input  logic [aes_package::BLOCK_W-1:0]    key_i,
  output logic [aes_package::BLOCK_W-1:0]    result_o
);

  logic [aes_package::BLOCK_W-1:0] state_q;

  // AddRoundKey, result held until the next job
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      state_q <= '0;
    else if (mix_en_i)
      state_q <= block_i ^ key_i;
  end

  assign result_o = state_q;

endmodule

`default_nettype wire

//--- design/aes_top.sv
`default_nettype none

module aes_top (
  input  logic                                  clk,
  input  logic                                  reset_n,
  // Host register port
  input  logic                                  cfg_we_i,
  input  logic [aes_package::REG_ADDR_W-1:0]    cfg_addr_i,
  input  logic [aes_package::DATA_W-1:0]        cfg_wdata_i,
  output logic [aes_package::DATA_W-1:0]        cfg_rdata_o,
  // Read memory port
  output logic                                  rd_req_o,
  output logic [aes_package::DATA_W-1:0]        rd_addr_o,
  input  logic [aes_package::DATA_W-1:0]        rd_data_i,
  // Write memory port
  output logic                                  wr_en_o,
  output logic [aes_package::DATA_W-1:0]        wr_addr_o,
  output logic [aes_package::DATA_W-1:0]        wr_data_o,
  output logic                                  irq_o
);

  logic                            start;
  logic [aes_package::DATA_W-1:0]  src_base;
  logic [aes_package::DATA_W-1:0]  dst_base;
  logic [aes_package::BLOCK_W-1:0] key;
  logic                            load_start;
  logic                            mix_en;
  logic                            store_start;
  logic                            busy;
  logic                            load_done;
  logic                            store_done;
  logic [aes_package::BLOCK_W-1:0] block;
  logic [aes_package::BLOCK_W-1:0] result;

  aes_regfile aes_regfile_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .busy_i      (busy),
    .done_i      (irq_o),
    .start_o     (start),
    .src_base_o  (src_base),
    .dst_base_o  (dst_base),
    .key_o       (key)
  );

  // Done pulse doubles as the interrupt
  aes_fsm aes_fsm_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .start_i       (start),
    .load_done_i   (load_done),
    .store_done_i  (store_done),
    .load_start_o  (load_start),
    .mix_en_o      (mix_en),
    .store_start_o (store_start),
    .busy_o        (busy),
    .done_o        (irq_o)
  );

  aes_source aes_source_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .load_start_i (load_start),
    .src_base_i   (src_base),
    .rd_req_o     (rd_req_o),
    .rd_addr_o    (rd_addr_o),
    .rd_data_i    (rd_data_i),
    .load_done_o  (load_done),
    .block_o      (block)
  );

  aes_add_round_key aes_add_round_key_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .mix_en_i (mix_en),
    .block_i  (block),
    .key_i    (key),
    .result_o (result)
  );

  aes_sink aes_sink_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .store_start_i (store_start),
    .dst_base_i    (dst_base),
    .result_i      (result),
    .wr_en_o       (wr_en_o),
    .wr_addr_o     (wr_addr_o),
    .wr_data_o     (wr_data_o),
    .store_done_o  (store_done)
  );

endmodule

`default_nettype wire

//--- test/tb_aes_top.sv
`default_nettype none

module tb_aes_top;

  localparam int TIMEOUT_CYCLES = 50;

  logic        clk;
  logic        reset_n;
  logic        cfg_we_i;
  logic [aes_package::REG_ADDR_W-1:0] cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic [31:0] cfg_rdata_o;
  logic        rd_req_o;
  logic [31:0] rd_addr_o;
  logic [31:0] rd_data_i;
  logic        wr_en_o;
  logic [31:0] wr_addr_o;
  logic [31:0] wr_data_o;
  logic        irq_o;

  // Memory model state
  logic [31:0] mem [256];
  logic        rd_pending;
  logic [7:0]  rd_idx;
  int          wr_count;
  int          irq_count;
  integer      seed;
  logic [31:0] src_lo;
  logic [31:0] dst_lo;
  logic [127:0] blk_a;
  logic [127:0] blk_b;
  logic [127:0] blk_c;
  logic [127:0] blk_d;

  aes_top aes_top_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_i   (rd_data_i),
    .wr_en_o     (wr_en_o),
    .wr_addr_o   (wr_addr_o),
    .wr_data_o   (wr_data_o),
    .irq_o       (irq_o)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("Error at time %0t: %s is 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
  endtask

  // Protocol checks
  quiet_in_reset: assert property (@(posedge clk)
    !reset_n |-> (!rd_req_o && !wr_en_o && !irq_o))
    else abort_run("Memory strobe or irq_o active while reset is applied");
  irq_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    irq_o |=> !irq_o)
    else abort_run("irq_o stayed high for more than one cycle");
  writes_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    wr_en_o |-> (wr_addr_o >= dst_lo && wr_addr_o < dst_lo + 32'd16))
    else abort_run("Write landed outside the programmed destination range");
  reads_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    rd_req_o |-> (rd_addr_o >= src_lo && rd_addr_o < src_lo + 32'd16))
    else abort_run("Read issued outside the programmed source range");

  function automatic logic [7:0] word_idx(input logic [31:0] base, input int k);
    return 8'((base >> 2) + 32'(k));
  endfunction

  function automatic logic [aes_package::REG_ADDR_W-1:0] key_reg(input int k);
    return aes_package::REG_ADDR_W'(int'(aes_package::AES_REG_KEY0) + k);
  endfunction

  // Memory answers at each falling edge the read seen one cycle earlier
  task automatic next_cycle();
    @(negedge clk);
    rd_data_i = rd_pending ? mem[rd_idx] : 32'h0;
    rd_pending = rd_req_o;
    rd_idx = rd_addr_o[9:2];
    if (wr_en_o === 1'b1) begin
      mem[wr_addr_o[9:2]] = wr_data_o;
      wr_count++;
    end
    if (irq_o === 1'b1)
      irq_count++;
  endtask

  task automatic reg_write(input logic [aes_package::REG_ADDR_W-1:0] addr,
                           input logic [31:0] data);
    cfg_we_i = 1'b1;
    cfg_addr_i = addr;
    cfg_wdata_i = data;
    next_cycle();
    cfg_we_i = 1'b0;
  endtask

  task automatic reg_read(input logic [aes_package::REG_ADDR_W-1:0] addr,
                          output logic [31:0] data);
    cfg_addr_i = addr;
    #5;
    data = cfg_rdata_o;
    next_cycle();
  endtask

  // Polls STATUS each cycle until irq_o and can retrigger mid-job
  task automatic wait_for_irq(input bit retrigger);
    int cycles;
    logic [31:0] status;
    cycles = 0;
    while (irq_o !== 1'b1) begin
      if (cycles >= TIMEOUT_CYCLES)
        abort_run($sformatf("No irq_o within %0d cycles of the trigger", TIMEOUT_CYCLES));
      if (retrigger && cycles == 4) begin
        cfg_we_i = 1'b1;
        cfg_addr_i = aes_package::AES_REG_TRIGGER;
        cfg_wdata_i = $random(seed);
      end else begin
        cfg_we_i = 1'b0;
        cfg_addr_i = aes_package::AES_REG_STATUS;
        #5;
        status = cfg_rdata_o;
        check_value("status busy bit", 32'(status[aes_package::STATUS_BUSY_BIT]), 32'd1);
      end
      next_cycle();
      cycles++;
    end
    cfg_we_i = 1'b0;
  endtask

  task automatic check_block(input logic [31:0] dst, input logic [127:0] exp_blk);
    for (int k = 0; k < 4; k++)
      check_value($sformatf("dst word %0d at 0x%03h", k, dst + 32'(4 * k)),
                  mem[word_idx(dst, k)], exp_blk[32*k +: 32]);
  endtask

  task automatic run_job(input logic [31:0] src, input logic [31:0] dst,
                         input bit retrigger, output logic [127:0] exp_blk);
    logic [127:0] plain;
    logic [127:0] key;
    logic [31:0]  got;
    logic [31:0]  exp_status;
    int           writes_before;
    int           irqs_before;
    for (int k = 0; k < 4; k++) begin
      plain[32*k +: 32] = $random(seed);
      key[32*k +: 32] = $random(seed);
      mem[word_idx(src, k)] = plain[32*k +: 32];
    end
    src_lo = src;
    dst_lo = dst;
    reg_write(aes_package::AES_REG_SRC_BASE, src);
    reg_write(aes_package::AES_REG_DST_BASE, dst);
    for (int k = 0; k < 4; k++)
      reg_write(key_reg(k), key[32*k +: 32]);
    reg_read(aes_package::AES_REG_SRC_BASE, got);
    check_value("src_base readback", got, src);
    reg_read(aes_package::AES_REG_DST_BASE, got);
    check_value("dst_base readback", got, dst);
    for (int k = 0; k < 4; k++) begin
      reg_read(key_reg(k), got);
      check_value($sformatf("key%0d readback", k), got, key[32*k +: 32]);
    end
    writes_before = wr_count;
    irqs_before = irq_count;
    reg_write(aes_package::AES_REG_TRIGGER, $random(seed));
    wait_for_irq(retrigger);
    // The irq_o cycle is the last busy cycle, so this trigger must be dropped
    if (retrigger)
      reg_write(aes_package::AES_REG_TRIGGER, $random(seed));
    else
      next_cycle();
    exp_status = '0;
    exp_status[aes_package::STATUS_DONE_BIT] = 1'b1;
    reg_read(aes_package::AES_REG_STATUS, got);
    check_value("status after irq_o", got, exp_status);
    // Quiet period shows up any extra job
    repeat (16) next_cycle();
    check_value("irq_o pulse count", 32'(irq_count - irqs_before), 32'd1);
    check_value("memory write count", 32'(wr_count - writes_before), 32'd4);
    exp_blk = plain ^ key;
    check_block(dst, exp_blk);
    for (int k = 0; k < 4; k++)
      check_value($sformatf("src word %0d", k), mem[word_idx(src, k)], plain[32*k +: 32]);
  endtask

  initial begin
    logic [31:0] status;
    clk = 1'b0;
    reset_n = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    rd_data_i = '0;
    rd_pending = 1'b0;
    rd_idx = '0;
    wr_count = 0;
    irq_count = 0;
    seed = 32'hd4ab_a572;
    src_lo = '0;
    dst_lo = '0;
    for (int i = 0; i < 256; i++)
      mem[i] = {8'hc3, 8'(i), ~8'(i), 8'(i)};
    repeat (3) next_cycle();
    reset_n = 1'b1;
    check_value("rd_req_o after reset", 32'(rd_req_o), 32'd0);
    check_value("wr_en_o after reset", 32'(wr_en_o), 32'd0);
    check_value("irq_o after reset", 32'(irq_o), 32'd0);
    reg_read(aes_package::AES_REG_STATUS, status);
    check_value("status after reset", status, 32'd0);

    run_job(32'h000, 32'h100, 1'b0, blk_a);
    // Second trigger lands while the job runs
    run_job(32'h040, 32'h180, 1'b1, blk_b);
    run_job(32'h200, 32'h300, 1'b0, blk_c);
    run_job(32'h240, 32'h3c0, 1'b0, blk_d);
    check_block(32'h100, blk_a);
    check_block(32'h180, blk_b);
    check_block(32'h300, blk_c);
    check_block(32'h3c0, blk_d);
    check_value("total irq_o pulses", 32'(irq_count), 32'd4);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
design/aes_package.sv
design/aes_regfile.sv
design/aes_fsm.sv
design/aes_source.sv
design/aes_sink.sv
design/aes_add_round_key.sv
design/aes_top.sv
test/tb_aes_top.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_aes_top -f list.f -o tb_aes_top \
  && ./obj_dir/tb_aes_top | tee sim.log
grep -qx "Done: no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
